// File: dual_issue_dpath.f
hw/dpath_pkg.sv
hw/int_alu.sv
hw/exec_lane.sv
hw/issue_read.sv
hw/reorder_buffer.sv
hw/dual_issue_dpath.sv
bench/tb_dual_issue_dpath.sv

// File: Makefile
# Verilator lint, simulation and clean rules for the dual-lane datapath

TOP = tb_dual_issue_dpath

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f dual_issue_dpath.f --top-module dual_issue_dpath
	verilator --lint-only --timing --assert -f dual_issue_dpath.f --top-module $(TOP)

# Pass or fail is read back from the simulation log
sim:
	verilator --binary --timing --assert -f dual_issue_dpath.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_dual_issue_dpath.sv
// Testbench for the dual-lane integer datapath
// LCG stimulus, cycle-by-cycle reference model and immediate assertions
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue_dpath
  import dpath_pkg::*;
();

  localparam int NUM_LANES = 2;
  localparam int SLOT_W    = $clog2(ROB_DEPTH);
  localparam int DRAIN_MAX = 20;

  typedef logic [SLOT_W-1:0] slot_t;

  logic      clk;
  logic      reset;
  logic      issue_val       [NUM_LANES];
  inst_t     issue_inst      [NUM_LANES];
  alu_fn_t   issue_fn        [NUM_LANES];
  op0_sel_t  issue_op0_sel   [NUM_LANES];
  op1_sel_t  issue_op1_sel   [NUM_LANES];
  slot_t     issue_src0_slot [NUM_LANES];
  slot_t     issue_src1_slot [NUM_LANES];
  slot_t     issue_dst_slot  [NUM_LANES];
  logic      commit_val      [NUM_COMMIT];
  slot_t     commit_slot     [NUM_COMMIT];
  reg_addr_t commit_waddr    [NUM_COMMIT];
  logic      wb_val          [NUM_LANES];
  slot_t     wb_slot         [NUM_LANES];
  data_t     wb_data         [NUM_LANES];
  data_t     commit_data     [NUM_COMMIT];

  dual_issue_dpath #(
    .NUM_LANES (NUM_LANES),
    .ROB_DEPTH (ROB_DEPTH)
  ) u_dual_issue_dpath (
    .clk             (clk),
    .reset           (reset),
    .issue_val       (issue_val),
    .issue_inst      (issue_inst),
    .issue_fn        (issue_fn),
    .issue_op0_sel   (issue_op0_sel),
    .issue_op1_sel   (issue_op1_sel),
    .issue_src0_slot (issue_src0_slot),
    .issue_src1_slot (issue_src1_slot),
    .issue_dst_slot  (issue_dst_slot),
    .commit_val      (commit_val),
    .commit_slot     (commit_slot),
    .commit_waddr    (commit_waddr),
    .wb_val          (wb_val),
    .wb_slot         (wb_slot),
    .wb_data         (wb_data),
    .commit_data     (commit_data)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Model state and pipeline of expected writebacks, index 1 is the older stage
  data_t       m_rf    [32];
  data_t       m_slot  [ROB_DEPTH];
  logic        m_known [ROB_DEPTH];
  logic        p_val   [2][NUM_LANES];
  slot_t       p_slot  [2][NUM_LANES];
  data_t       p_data  [2][NUM_LANES];
  logic        p_known [2][NUM_LANES];
  int          errors   = 0;
  int          checks   = 0;
  int          timeouts = 0;
  logic [31:0] seed     = 32'hc663;
  string       test_name;
  int          test_checks;
  int          test_errors;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic slot_t rand_slot(int base, int span);
    logic [31:0] r;
    r = next_rand();
    return slot_t'(base + int'(r[23:8]) % span);
  endfunction

  function automatic inst_t with_regs(inst_t base, reg_addr_t rs1, reg_addr_t rs2);
    inst_t ins;
    ins = base;
    ins[19:15] = rs1;
    ins[24:20] = rs2;
    return ins;
  endfunction

  // Expected ALU result from the function definitions
  function automatic data_t ref_alu(alu_fn_t fn, data_t a, data_t b);
    data_t res;
    case (fn)
      ALU_ADD:   res = a + b;
      ALU_SUB:   res = a - b;
      ALU_SLL:   res = a << b[4:0];
      ALU_SLT:   res = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
      ALU_SLTU:  res = {31'd0, a < b};
      ALU_XOR:   res = a ^ b;
      ALU_SRL:   res = a >> b[4:0];
      ALU_SRA: begin
        res = a >> b[4:0];
        if (a[31])
          res = res | ~(32'hffff_ffff >> b[4:0]);
      end
      ALU_OR:    res = a | b;
      ALU_AND:   res = a & b;
      ALU_PASS1: res = b;
      default:   res = '0;
    endcase
    return res;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  // ------------------------------------------------------------------------
  // Reference model, one step per cycle at the falling edge
  // ------------------------------------------------------------------------

  always @(negedge clk) begin : model_step
    logic  n_val   [NUM_LANES];
    slot_t n_slot  [NUM_LANES];
    data_t n_data  [NUM_LANES];
    logic  n_known [NUM_LANES];
    data_t a;
    data_t b;
    logic  ka;
    logic  kb;
    if (reset) begin
      for (int r = 0; r < 32; r++)
        m_rf[r] = '0;
      for (int s = 0; s < ROB_DEPTH; s++)
        m_known[s] = 1'b0;
      for (int l = 0; l < NUM_LANES; l++) begin
        p_val[0][l] = 1'b0;
        p_val[1][l] = 1'b0;
      end
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        check_value($sformatf("wb_val[%0d]", l), 32'(p_val[1][l]), 32'(wb_val[l]));
        if (p_val[1][l]) begin
          check_value($sformatf("wb_slot[%0d]", l), 32'(p_slot[1][l]), 32'(wb_slot[l]));
          if (p_known[1][l])
            check_value($sformatf("wb_data[%0d]", l), p_data[1][l], wb_data[l]);
        end
      end
      for (int p = 0; p < NUM_COMMIT; p++)
        if (commit_val[p] && m_known[commit_slot[p]])
          check_value($sformatf("commit_data[%0d]", p), m_slot[commit_slot[p]], commit_data[p]);
      // Operands see the state from before the coming edge
      for (int l = 0; l < NUM_LANES; l++) begin
        ka = 1'b1;
        kb = 1'b1;
        case (issue_op0_sel[l])
          OP_REG: a = m_rf[issue_inst[l][19:15]];
          OP_ROB: begin
            a  = m_slot[issue_src0_slot[l]];
            ka = m_known[issue_src0_slot[l]];
          end
          default: a = '0;
        endcase
        case (issue_op1_sel[l])
          OP_REG: b = m_rf[issue_inst[l][24:20]];
          OP_ROB: begin
            b  = m_slot[issue_src1_slot[l]];
            kb = m_known[issue_src1_slot[l]];
          end
          OP_IMM:  b = {{20{issue_inst[l][31]}}, issue_inst[l][31:20]};
          default: b = '0;
        endcase
        n_val[l]   = issue_val[l];
        n_slot[l]  = issue_dst_slot[l];
        n_data[l]  = ref_alu(issue_fn[l], a, b);
        n_known[l] = ka && kb;
      end
      // Commit reads the slot before this edge's writeback, port 1 last
      for (int p = 0; p < NUM_COMMIT; p++)
        if (commit_val[p] && commit_waddr[p] != 5'd0)
          m_rf[commit_waddr[p]] = m_slot[commit_slot[p]];
      for (int l = 0; l < NUM_LANES; l++) begin
        if (p_val[1][l]) begin
          m_slot[p_slot[1][l]]  = p_data[1][l];
          m_known[p_slot[1][l]] = p_known[1][l];
        end
        p_val[1][l]   = p_val[0][l];
        p_slot[1][l]  = p_slot[0][l];
        p_data[1][l]  = p_data[0][l];
        p_known[1][l] = p_known[0][l];
        p_val[0][l]   = n_val[l];
        p_slot[0][l]  = n_slot[l];
        p_data[0][l]  = n_data[l];
        p_known[0][l] = n_known[l];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------------------

  task automatic next_cycle();
    @(posedge clk);
    for (int l = 0; l < NUM_LANES; l++)
      issue_val[l] <= 1'b0;
    for (int p = 0; p < NUM_COMMIT; p++)
      commit_val[p] <= 1'b0;
  endtask

  task automatic set_issue(int lane, alu_fn_t fn, inst_t inst, op0_sel_t sel0,
                           op1_sel_t sel1, slot_t src0, slot_t src1, slot_t dst);
    issue_val[lane]       <= 1'b1;
    issue_fn[lane]        <= fn;
    issue_inst[lane]      <= inst;
    issue_op0_sel[lane]   <= sel0;
    issue_op1_sel[lane]   <= sel1;
    issue_src0_slot[lane] <= src0;
    issue_src1_slot[lane] <= src1;
    issue_dst_slot[lane]  <= dst;
  endtask

  task automatic set_commit(int port, slot_t slot, reg_addr_t waddr);
    commit_val[port]   <= 1'b1;
    commit_slot[port]  <= slot;
    commit_waddr[port] <= waddr;
  endtask

  task automatic start_test(string name);
    test_name   = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test();
    $display("%s: %0d checks, %0d errors", test_name, checks - test_checks,
             errors - test_errors);
  endtask

  task automatic finish_run();
    $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  // Idle until no result is in flight in either lane
  task automatic wait_drain();
    int   n;
    logic busy;
    n    = 0;
    busy = 1'b1;
    while (busy && n < DRAIN_MAX) begin
      next_cycle();
      n++;
      busy = 1'b0;
      for (int l = 0; l < NUM_LANES; l++)
        if (p_val[0][l] || p_val[1][l])
          busy = 1'b1;
    end
    if (busy) begin
      timeouts++;
      $display("Timeout: %s still had results in flight after %0d cycles", test_name, n);
    end
  endtask

  initial begin : stimulus
    int        k;
    op0_sel_t  s0;
    reg_addr_t rg;
    reset <= 1'b1;
    for (int l = 0; l < NUM_LANES; l++) begin
      issue_val[l]       <= 1'b0;
      issue_inst[l]      <= '0;
      issue_fn[l]        <= ALU_ADD;
      issue_op0_sel[l]   <= OP_ZERO;
      issue_op1_sel[l]   <= OP_ZERO;
      issue_src0_slot[l] <= '0;
      issue_src1_slot[l] <= '0;
      issue_dst_slot[l]  <= '0;
    end
    for (int p = 0; p < NUM_COMMIT; p++) begin
      commit_val[p]   <= 1'b0;
      commit_slot[p]  <= '0;
      commit_waddr[p] <= '0;
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // Every register reads zero, and the sums fill all slots
    start_test("reset");
    for (k = 0; k < ROB_DEPTH / 2; k++) begin
      next_cycle();
      for (int l = 0; l < NUM_LANES; l++) begin
        rg = reg_addr_t'(2 * k + l);
        set_issue(l, ALU_ADD, with_regs(next_rand(), rg, rg), OP_REG, OP_REG,
                  '0, '0, slot_t'(2 * k + l));
      end
    end
    wait_drain();
    end_test();

    start_test("immediate");
    for (k = 0; k < 8; k++) begin
      next_cycle();
      for (int l = 0; l < NUM_LANES; l++)
        set_issue(l, alu_fn_t'(next_rand() >> 12), next_rand(), OP_ZERO, OP_IMM,
                  '0, '0, slot_t'(2 * k + l));
    end
    wait_drain();
    end_test();

    start_test("commit");
    // Distinct values in the two slots later committed to one register
    next_cycle();
    set_issue(0, ALU_PASS1, 32'h0010_0000, OP_ZERO, OP_IMM, '0, '0, slot_t'(3));
    set_issue(1, ALU_PASS1, 32'h0020_0000, OP_ZERO, OP_IMM, '0, '0, slot_t'(4));
    wait_drain();
    next_cycle();
    set_commit(0, slot_t'(1), reg_addr_t'(5));
    set_commit(1, slot_t'(2), reg_addr_t'(6));
    // Both ports name register 7
    next_cycle();
    set_commit(0, slot_t'(3), reg_addr_t'(7));
    set_commit(1, slot_t'(4), reg_addr_t'(7));
    // Register 0 drops the write, register 9 is read while being written
    next_cycle();
    set_commit(0, slot_t'(5), reg_addr_t'(0));
    set_commit(1, slot_t'(6), reg_addr_t'(9));
    set_issue(0, ALU_PASS1, with_regs('0, '0, reg_addr_t'(9)), OP_ZERO, OP_REG,
              '0, '0, slot_t'(16));
    // Register 7 holds the port 1 value
    set_issue(1, ALU_PASS1, with_regs('0, '0, reg_addr_t'(7)), OP_ZERO, OP_REG,
              '0, '0, slot_t'(17));
    for (k = 0; k < 6; k++) begin
      next_cycle();
      set_commit(0, rand_slot(0, 16), reg_addr_t'(next_rand() >> 20));
      set_commit(1, rand_slot(0, 16), reg_addr_t'(next_rand() >> 20));
    end
    for (k = 0; k < 32; k++) begin
      next_cycle();
      rg = reg_addr_t'(k);
      set_issue(0, ALU_ADD, with_regs(next_rand(), rg, 5'd0), OP_REG, OP_ZERO,
                '0, '0, slot_t'(16 + k % 8));
      set_issue(1, ALU_PASS1, with_regs(next_rand(), 5'd0, rg), OP_ZERO, OP_REG,
                '0, '0, slot_t'(24 + k % 8));
    end
    wait_drain();
    end_test();

    start_test("rob bypass");
    for (k = 0; k < 8; k++) begin
      next_cycle();
      for (int l = 0; l < NUM_LANES; l++)
        set_issue(l, alu_fn_t'(next_rand() >> 12), next_rand(), OP_ROB,
                  (k % 2 == 0) ? OP_ROB : OP_IMM, rand_slot(0, 16), rand_slot(0, 16),
                  slot_t'(16 + 2 * k + l));
    end
    wait_drain();
    end_test();

    start_test("back to back");
    for (k = 0; k < 12; k++) begin
      next_cycle();
      for (int l = 0; l < NUM_LANES; l++) begin
        s0 = op0_sel_t'(next_rand() >> 14);
        if (s0 == OP_IMM)
          s0 = OP_ZERO;
        set_issue(l, alu_fn_t'(next_rand() >> 12),
                  with_regs(next_rand(), reg_addr_t'(next_rand() >> 20),
                            reg_addr_t'(next_rand() >> 24)),
                  s0, op1_sel_t'(next_rand() >> 16), rand_slot(0, 32), rand_slot(0, 32),
                  slot_t'(2 * k + l));
      end
    end
    wait_drain();
    end_test();

    finish_run();
  end

endmodule

`default_nettype wire

// File: hw/dual_issue_dpath.sv
// Dual-lane integer datapath top level
// Issue read, generated execute lanes and the reorder buffer
`timescale 1ns/1ps
`default_nettype none

module dual_issue_dpath
  import dpath_pkg::*;
#(
  parameter int NUM_LANES = 2,
  parameter int ROB_DEPTH = dpath_pkg::ROB_DEPTH
) (
  input  logic                         clk,
  input  logic                         reset,

  // Issue per lane
  input  logic                         issue_val       [NUM_LANES],
  input  inst_t                        issue_inst      [NUM_LANES],
  input  alu_fn_t                      issue_fn        [NUM_LANES],
  input  op0_sel_t                     issue_op0_sel   [NUM_LANES],
  input  op1_sel_t                     issue_op1_sel   [NUM_LANES],
  input  logic [$clog2(ROB_DEPTH)-1:0] issue_src0_slot [NUM_LANES],
  input  logic [$clog2(ROB_DEPTH)-1:0] issue_src1_slot [NUM_LANES],
  input  logic [$clog2(ROB_DEPTH)-1:0] issue_dst_slot  [NUM_LANES],

  // Commit per port
  input  logic                         commit_val      [NUM_COMMIT],
  input  logic [$clog2(ROB_DEPTH)-1:0] commit_slot     [NUM_COMMIT],
  input  reg_addr_t                    commit_waddr    [NUM_COMMIT],

  // Writeback per lane
  output logic                         wb_val          [NUM_LANES],
  output logic [$clog2(ROB_DEPTH)-1:0] wb_slot         [NUM_LANES],
  output data_t                        wb_data         [NUM_LANES],

  output data_t                        commit_data     [NUM_COMMIT]
);

  localparam int SLOT_W = $clog2(ROB_DEPTH);

  // Issue to execute
  logic              x_val      [NUM_LANES];
  alu_fn_t           x_fn       [NUM_LANES];
  data_t             x_op0      [NUM_LANES];
  data_t             x_op1      [NUM_LANES];
  logic [SLOT_W-1:0] x_dst_slot [NUM_LANES];

  // Reorder buffer bypass and commit write
  data_t             rob_rdata0 [NUM_LANES];
  data_t             rob_rdata1 [NUM_LANES];
  logic              rf_wen     [NUM_COMMIT];
  reg_addr_t         rf_waddr   [NUM_COMMIT];
  data_t             rf_wdata   [NUM_COMMIT];

  issue_read #(
    .NUM_LANES (NUM_LANES),
    .ROB_DEPTH (ROB_DEPTH)
  ) u_issue_read (
    .clk            (clk),
    .reset          (reset),
    .issue_val      (issue_val),
    .issue_inst     (issue_inst),
    .issue_fn       (issue_fn),
    .issue_op0_sel  (issue_op0_sel),
    .issue_op1_sel  (issue_op1_sel),
    .issue_dst_slot (issue_dst_slot),
    .rob_rdata0     (rob_rdata0),
    .rob_rdata1     (rob_rdata1),
    .rf_wen         (rf_wen),
    .rf_waddr       (rf_waddr),
    .rf_wdata       (rf_wdata),
    .x_val          (x_val),
    .x_fn           (x_fn),
    .x_op0          (x_op0),
    .x_op1          (x_op1),
    .x_dst_slot     (x_dst_slot)
  );

  // ------------------------------------------------------------------------
  // Execute lanes
  // ------------------------------------------------------------------------

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    exec_lane #(
      .ROB_DEPTH (ROB_DEPTH)
    ) u_exec_lane (
      .clk        (clk),
      .reset      (reset),
      .x_val      (x_val[i]),
      .x_fn       (x_fn[i]),
      .x_op0      (x_op0[i]),
      .x_op1      (x_op1[i]),
      .x_dst_slot (x_dst_slot[i]),
      .wb_val     (wb_val[i]),
      .wb_slot    (wb_slot[i]),
      .wb_data    (wb_data[i])
    );
  end

  // Bypass addresses come straight from the issue inputs
  reorder_buffer #(
    .NUM_LANES (NUM_LANES),
    .ROB_DEPTH (ROB_DEPTH)
  ) u_reorder_buffer (
    .clk          (clk),
    .wb_val       (wb_val),
    .wb_slot      (wb_slot),
    .wb_data      (wb_data),
    .rd_slot0     (issue_src0_slot),
    .rd_slot1     (issue_src1_slot),
    .rob_rdata0   (rob_rdata0),
    .rob_rdata1   (rob_rdata1),
    .commit_val   (commit_val),
    .commit_slot  (commit_slot),
    .commit_waddr (commit_waddr),
    .commit_data  (commit_data),
    .rf_wen       (rf_wen),
    .rf_waddr     (rf_waddr),
    .rf_wdata     (rf_wdata)
  );

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
// Reorder buffer slot storage
// Lane fills, bypass reads and the in-order commit ports
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
  import dpath_pkg::*;
#(
  parameter int NUM_LANES = 2,
  parameter int ROB_DEPTH = dpath_pkg::ROB_DEPTH
) (
  input  logic                         clk,

  // Lane writeback
  input  logic                         wb_val       [NUM_LANES],
  input  logic [$clog2(ROB_DEPTH)-1:0] wb_slot      [NUM_LANES],
  input  data_t                        wb_data      [NUM_LANES],

  // Bypass reads for the issue stage
  input  logic [$clog2(ROB_DEPTH)-1:0] rd_slot0     [NUM_LANES],
  input  logic [$clog2(ROB_DEPTH)-1:0] rd_slot1     [NUM_LANES],
  output data_t                        rob_rdata0   [NUM_LANES],
  output data_t                        rob_rdata1   [NUM_LANES],

  // Commit requests
  input  logic                         commit_val   [NUM_COMMIT],
  input  logic [$clog2(ROB_DEPTH)-1:0] commit_slot  [NUM_COMMIT],
  input  reg_addr_t                    commit_waddr [NUM_COMMIT],
  output data_t                        commit_data  [NUM_COMMIT],

  // Register file write
  output logic                         rf_wen       [NUM_COMMIT],
  output reg_addr_t                    rf_waddr     [NUM_COMMIT],
  output data_t                        rf_wdata     [NUM_COMMIT]
);

  data_t slots [ROB_DEPTH];

  // Higher lane index wins a shared slot
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (wb_val[i]) begin
        slots[wb_slot[i]] <= wb_data[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rob_rdata0[i] = slots[rd_slot0[i]];
      rob_rdata1[i] = slots[rd_slot1[i]];
    end
    for (int p = 0; p < NUM_COMMIT; p++) begin
      commit_data[p] = slots[commit_slot[p]];
      // Register 0 is never written
      rf_wen[p]      = commit_val[p] && (commit_waddr[p] != '0);
      rf_waddr[p]    = commit_waddr[p];
      rf_wdata[p]    = commit_data[p];
    end
  end

endmodule

`default_nettype wire

// File: hw/issue_read.sv
// Issue stage register read
// Register file, instruction field decode and operand selection per lane
`timescale 1ns/1ps
`default_nettype none

module issue_read
  import dpath_pkg::*;
#(
  parameter int NUM_LANES = 2,
  parameter int ROB_DEPTH = dpath_pkg::ROB_DEPTH
) (
  input  logic                         clk,
  input  logic                         reset,

  // Issue inputs per lane
  input  logic                         issue_val      [NUM_LANES],
  input  inst_t                        issue_inst     [NUM_LANES],
  input  alu_fn_t                      issue_fn       [NUM_LANES],
  input  op0_sel_t                     issue_op0_sel  [NUM_LANES],
  input  op1_sel_t                     issue_op1_sel  [NUM_LANES],
  input  logic [$clog2(ROB_DEPTH)-1:0] issue_dst_slot [NUM_LANES],

  // Bypass data from the reorder buffer
  input  data_t                        rob_rdata0     [NUM_LANES],
  input  data_t                        rob_rdata1     [NUM_LANES],

  // Commit writes into the register file
  input  logic                         rf_wen         [NUM_COMMIT],
  input  reg_addr_t                    rf_waddr       [NUM_COMMIT],
  input  data_t                        rf_wdata       [NUM_COMMIT],

  // To the execute lanes
  output logic                         x_val          [NUM_LANES],
  output alu_fn_t                      x_fn           [NUM_LANES],
  output data_t                        x_op0          [NUM_LANES],
  output data_t                        x_op1          [NUM_LANES],
  output logic [$clog2(ROB_DEPTH)-1:0] x_dst_slot     [NUM_LANES]
);

  localparam int NUM_REGS = 2 ** $bits(reg_addr_t);

  // ------------------------------------------------------------------------
  // Register file
  // ------------------------------------------------------------------------

  data_t rf [NUM_REGS];

  // Later commit port takes priority on a shared register
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        rf[r] <= '0;
      end
    end else begin
      for (int p = 0; p < NUM_COMMIT; p++) begin
        if (rf_wen[p]) begin
          rf[rf_waddr[p]] <= rf_wdata[p];
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Field decode and operand muxes
  // ------------------------------------------------------------------------

  reg_addr_t rs1       [NUM_LANES];
  reg_addr_t rs2       [NUM_LANES];
  data_t     imm_i     [NUM_LANES];
  data_t     rf_rdata0 [NUM_LANES];
  data_t     rf_rdata1 [NUM_LANES];

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      // Standard RISC-V field positions
      rs1[i]   = issue_inst[i][19:15];
      rs2[i]   = issue_inst[i][24:20];
      imm_i[i] = {{20{issue_inst[i][31]}}, issue_inst[i][31:20]};

      rf_rdata0[i] = (rs1[i] == '0) ? '0 : rf[rs1[i]];
      rf_rdata1[i] = (rs2[i] == '0) ? '0 : rf[rs2[i]];

      case (issue_op0_sel[i])
        OP_REG:  x_op0[i] = rf_rdata0[i];
        OP_ROB:  x_op0[i] = rob_rdata0[i];
        default: x_op0[i] = '0;
      endcase

      case (issue_op1_sel[i])
        OP_REG:  x_op1[i] = rf_rdata1[i];
        OP_ROB:  x_op1[i] = rob_rdata1[i];
        OP_IMM:  x_op1[i] = imm_i[i];
        default: x_op1[i] = '0;
      endcase

      // Control travels with the operands
      x_val[i]      = issue_val[i];
      x_fn[i]       = issue_fn[i];
      x_dst_slot[i] = issue_dst_slot[i];
    end
  end

endmodule

`default_nettype wire

// File: hw/exec_lane.sv
// One execute lane
// Operand register, ALU and writeback register, two cycles issue to writeback
`timescale 1ns/1ps
`default_nettype none

module exec_lane
  import dpath_pkg::*;
#(
  parameter int ROB_DEPTH = dpath_pkg::ROB_DEPTH
) (
  input  logic                         clk,
  input  logic                         reset,

  // Issue side, combinational in the issue cycle
  input  logic                         x_val,
  input  alu_fn_t                      x_fn,
  input  data_t                        x_op0,
  input  data_t                        x_op1,
  input  logic [$clog2(ROB_DEPTH)-1:0] x_dst_slot,

  // Writeback to the reorder buffer
  output logic                         wb_val,
  output logic [$clog2(ROB_DEPTH)-1:0] wb_slot,
  output data_t                        wb_data
);

  localparam int SLOT_W = $clog2(ROB_DEPTH);

  // ------------------------------------------------------------------------
  // Execute stage registers
  // ------------------------------------------------------------------------

  logic              ex_val;
  alu_fn_t           ex_fn;
  data_t             ex_op0;
  data_t             ex_op1;
  logic [SLOT_W-1:0] ex_slot;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_val <= 1'b0;
    end else begin
      ex_val <= x_val;
    end
  end

  always_ff @(posedge clk) begin
    ex_fn   <= x_fn;
    ex_op0  <= x_op0;
    ex_op1  <= x_op1;
    ex_slot <= x_dst_slot;
  end

  // ALU runs during the execute cycle
  data_t alu_out;

  int_alu u_int_alu (
    .in0 (ex_op0),
    .in1 (ex_op1),
    .fn  (ex_fn),
    .out (alu_out)
  );

  // ------------------------------------------------------------------------
  // Writeback stage registers
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_val <= 1'b0;
    end else begin
      wb_val <= ex_val;
    end
  end

  always_ff @(posedge clk) begin
    wb_slot <= ex_slot;
    wb_data <= alu_out;
  end

endmodule

`default_nettype wire

// File: hw/int_alu.sv
// Combinational integer ALU
// Add, subtract, shifts, compares, logic ops and operand-1 pass
`timescale 1ns/1ps
`default_nettype none

module int_alu
  import dpath_pkg::*;
(
  input  data_t   in0,
  input  data_t   in1,
  input  alu_fn_t fn,
  output data_t   out
);

  // Shift amount from the low bits of operand 1
  logic [4:0] shamt;

  assign shamt = in1[4:0];

  always_comb begin
    case (fn)
      ALU_ADD: begin
        out = in0 + in1;
      end
      ALU_SUB: begin
        out = in0 - in1;
      end
      ALU_SLL: begin
        out = in0 << shamt;
      end
      ALU_SLT: begin
        out = {31'd0, $signed(in0) < $signed(in1)};
      end
      ALU_SLTU: begin
        out = {31'd0, in0 < in1};
      end
      ALU_XOR: begin
        out = in0 ^ in1;
      end
      ALU_SRL: begin
        out = in0 >> shamt;
      end
      ALU_SRA: begin
        out = data_t'($signed(in0) >>> shamt);
      end
      ALU_OR: begin
        out = in0 | in1;
      end
      ALU_AND: begin
        out = in0 & in1;
      end
      ALU_PASS1: begin
        out = in1;
      end
      default: begin
        out = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/dpath_pkg.sv
// Shared datapath types for the dual-lane integer core
// ALU function codes and operand source select codes
`default_nettype none

package dpath_pkg;

  // Machine word and instruction word
  typedef logic [31:0] data_t;
  typedef logic [31:0] inst_t;

  // Architectural register index, register 0 reads as zero
  typedef logic [4:0]  reg_addr_t;

  // Control field types
  typedef logic [3:0]  alu_fn_t;
  typedef logic [1:0]  op0_sel_t;
  typedef logic [1:0]  op1_sel_t;

  // Default slot count and number of commit ports
  localparam int ROB_DEPTH  = 32;
  localparam int NUM_COMMIT = 2;

  // ALU functions, unlisted codes produce zero
  localparam alu_fn_t ALU_ADD   = 4'd0;
  localparam alu_fn_t ALU_SUB   = 4'd1;
  localparam alu_fn_t ALU_SLL   = 4'd2;
  localparam alu_fn_t ALU_SLT   = 4'd3;
  localparam alu_fn_t ALU_SLTU  = 4'd4;
  localparam alu_fn_t ALU_XOR   = 4'd5;
  localparam alu_fn_t ALU_SRL   = 4'd6;
  localparam alu_fn_t ALU_SRA   = 4'd7;
  localparam alu_fn_t ALU_OR    = 4'd8;
  localparam alu_fn_t ALU_AND   = 4'd9;
  localparam alu_fn_t ALU_PASS1 = 4'd10;

  // Operand sources
  // Operand 0 uses OP_REG, OP_ROB and OP_ZERO only
  localparam op1_sel_t OP_REG  = 2'd0;
  localparam op1_sel_t OP_ROB  = 2'd1;
  localparam op1_sel_t OP_IMM  = 2'd2;
  localparam op1_sel_t OP_ZERO = 2'd3;

endpackage

`default_nettype wire
